/* pokey_input_top.f */
common/pokey_pkg.sv
common/ctrl_pkg.sv
verilog/pokey_timing.sv
verilog/pokey_reg_decode.sv
keyboard/pokey_keyscan.sv
pots/pokey_potscan.sv
verilog/pokey_trig.sv
verilog/pokey_read_mux.sv
verilog/pokey_input_top.sv
verif/pokey_input_assertions.sv
verif/tb_pokey_input_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, status comes from the pass line
cd "$(dirname "$0")" || exit 1

out=""
verilator --binary --timing --assert \
    -f pokey_input_top.f \
    --top-module tb_pokey_input_top \
    -o sim_pokey_input &&
    out=$(./obj_dir/sim_pokey_input 2>&1)

echo "$out"
echo "$out" | grep -q "^Simulation PASSED$" && exit 0 || exit 1

/* verif/tb_pokey_input_top.sv */
`default_nettype none

module tb_pokey_input_top
    import pokey_pkg::*;
    import ctrl_pkg::*;
();

    // one full 16-step keypad scan in clocks
    localparam int SCAN_CLKS = 16 * O2_DIV;
    // dump, full count and some synchronizer slack
    localparam int POT_SCAN_CLKS = (POT_DUMP_TICKS + int'(POT_MAX) + 4) * O2_DIV;
    // delay that never ends inside a scan, pot stays open
    localparam int POT_HELD = 100000;
    // about 2400 clocks of tests, two pot scans dominate
    localparam int TIMEOUT_CYCLES = 6000;

    logic        clk_27mhz_fpga;
    logic        reset;
    logic [3:0]  addr;
    logic        wr_en;
    logic [7:0]  wr_data;
    ctrl_pads_t  pads;
    logic [7:0]  rd_data;
    ctrl_drive_t drive;
    logic [3:0]  trig;
    logic        irq;

    // keypad and button models
    logic        key_down;
    logic [3:0]  key_code;
    logic [3:0]  trig_l;
    logic        kr1_l;
    // pot models, clocks from release to rise
    logic [1:0]  pot_in = 2'b00;
    int          pot_delay [2];
    int          rise_cnt [2] = '{0, 0};

    int errors;
    int checks;
    int cycles = 0;

    pokey_input_top i_pokey_input_top (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .addr           (addr),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .pads           (pads),
        .rd_data        (rd_data),
        .drive          (drive),
        .trig           (trig),
        .irq            (irq)
    );

    initial begin
        clk_27mhz_fpga = 1'b0;
        forever #5 clk_27mhz_fpga = ~clk_27mhz_fpga;
    end

    // return line low while the held key is being scanned
    assign kr1_l = !(key_down && (drive.key_scan == key_code));
    assign pads  = {kr1_l, pot_in, trig_l};

    // each pot charges for its delay once released
    always @(posedge clk_27mhz_fpga) begin
        for (int i = 0; i < 2; i++) begin
            if (reset || !drive.pot_rel[i]) begin
                rise_cnt[i] <= 0;
                pot_in[i]   <= 1'b0;
            end else begin
                rise_cnt[i] <= rise_cnt[i] + 1;
                pot_in[i]   <= (rise_cnt[i] + 1 >= pot_delay[i]);
            end
        end
    end

    always @(posedge clk_27mhz_fpga) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d clocks", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        errors++;
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk_27mhz_fpga);
        addr    <= a;
        wr_data <= d;
        wr_en   <= 1'b1;
        @(posedge clk_27mhz_fpga);
        wr_en   <= 1'b0;
    endtask

    // rd_data is combinational, sampled mid-cycle
    task automatic read_reg(input logic [3:0] a, output logic [7:0] d);
        @(posedge clk_27mhz_fpga);
        addr  <= a;
        wr_en <= 1'b0;
        @(negedge clk_27mhz_fpga);
        d = rd_data;
    endtask

    task automatic expect_reg(input logic [3:0] a, input string name, input logic [7:0] exp);
        logic [7:0] got;
        read_reg(a, got);
        checks++;
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    // one count of slack for the pot line synchronizer
    task automatic check_pot_value(input logic [3:0] a, input string name, input int exp);
        logic [7:0] got;
        read_reg(a, got);
        checks++;
        if (int'(got) < exp - 1 || int'(got) > exp + 1) begin
            report_mismatch(name, got, 8'(exp));
        end
    endtask

    task automatic check_trig(input logic [3:0] exp);
        @(negedge clk_27mhz_fpga);
        checks++;
        if (trig !== exp) begin
            report_mismatch("trig", {4'h0, trig}, {4'h0, exp});
        end
    endtask

    task automatic wait_for_irq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            @(negedge clk_27mhz_fpga);
            n++;
        end
        checks++;
        if (!irq) begin
            errors++;
            $display("irq did not rise within %0d clocks of the key press", limit);
        end
    endtask

    // ALLPOT going to zero marks the end of a scan
    task automatic wait_pots_done();
        logic [7:0] ap;
        int         n;
        n = 0;
        read_reg(REG_ALLPOT, ap);
        while (ap != 8'h00 && n < POT_SCAN_CLKS * 2) begin
            read_reg(REG_ALLPOT, ap);
            n++;
        end
        checks++;
        if (ap != 8'h00) begin
            errors++;
            $display("pot scan did not finish, ALLPOT still nonzero");
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk_27mhz_fpga);
        checks++;
        if (irq !== 1'b0) begin
            report_mismatch("irq", {7'd0, irq}, 8'h00);
        end
        checks++;
        if (drive.pot_rel !== 2'b00) begin
            report_mismatch("pot_rel", {6'd0, drive.pot_rel}, 8'h00);
        end
        // scan counter starts at position 0
        checks++;
        if (drive.key_scan !== 4'h0) begin
            report_mismatch("key_scan", {4'h0, drive.key_scan}, 8'h00);
        end
        expect_reg(REG_SKCTL, "SKSTAT", 8'hff);
        expect_reg(REG_ALLPOT, "ALLPOT", 8'h00);
        expect_reg(REG_KBCODE, "KBCODE", 8'h00);
    endtask

    task automatic run_keyboard_test();
        write_reg(REG_SKCTL, 8'h01 << SKCTL_KEYSCAN_BIT);
        write_reg(REG_IRQ, 8'h01 << IRQ_KEY_BIT);
        key_code <= 4'd5;
        key_down <= 1'b1;
        // two agreeing scans, at worst after a partial one
        wait_for_irq(3 * SCAN_CLKS + 16);
        // code 5 reads back doubled
        expect_reg(REG_KBCODE, "KBCODE", 8'h0a);
        // key-down flag is active low in SKSTAT bit 2
        expect_reg(REG_SKCTL, "SKSTAT", 8'hfb);
        expect_reg(REG_IRQ, "IRQST", 8'hbf);
        write_reg(REG_IRQ, 8'h00);
        expect_reg(REG_IRQ, "IRQST", 8'hff);
        checks++;
        if (irq !== 1'b0) begin
            report_mismatch("irq", {7'd0, irq}, 8'h00);
        end
        @(posedge clk_27mhz_fpga);
        key_down <= 1'b0;
    endtask

    task automatic run_keyboard_disabled_test();
        logic irq_seen;
        irq_seen = 1'b0;
        write_reg(REG_SKCTL, 8'h00);
        write_reg(REG_IRQ, 8'h01 << IRQ_KEY_BIT);
        key_code <= 4'd9;
        key_down <= 1'b1;
        repeat (3 * SCAN_CLKS) begin
            @(negedge clk_27mhz_fpga);
            if (irq) begin
                irq_seen = 1'b1;
            end
        end
        checks++;
        if (irq_seen) begin
            errors++;
            $display("irq rose while keyboard scanning was disabled");
        end
        // code 5 from the previous test stays
        expect_reg(REG_KBCODE, "KBCODE", 8'h0a);
        @(posedge clk_27mhz_fpga);
        key_down <= 1'b0;
        write_reg(REG_IRQ, 8'h00);
    endtask

    task automatic run_pot_test();
        pot_delay[0] = 40;
        pot_delay[1] = 200;
        write_reg(REG_POTGO, 8'h00);
        wait_pots_done();
        // one count per phase-2 tick
        check_pot_value(REG_POT0, "POT0", pot_delay[0] / O2_DIV);
        check_pot_value(REG_POT1, "POT1", pot_delay[1] / O2_DIV);
        pot_delay[0] = 80;
        pot_delay[1] = POT_HELD;
        write_reg(REG_POTGO, 8'h00);
        wait_pots_done();
        check_pot_value(REG_POT0, "POT0", pot_delay[0] / O2_DIV);
        expect_reg(REG_POT1, "POT1", POT_MAX);
    endtask

    task automatic run_trigger_test();
        // live mode
        write_reg(REG_GRACTL, 8'h00);
        trig_l <= 4'b1011;
        repeat (3) @(posedge clk_27mhz_fpga);
        check_trig(~4'b1011);
        @(posedge clk_27mhz_fpga);
        trig_l <= 4'hf;
        repeat (3) @(posedge clk_27mhz_fpga);
        check_trig(4'h0);
        // latch mode, short press on button 1
        write_reg(REG_GRACTL, 8'h01 << GRACTL_LATCH_BIT);
        trig_l <= 4'b1101;
        repeat (3) @(posedge clk_27mhz_fpga);
        trig_l <= 4'hf;
        repeat (4) @(posedge clk_27mhz_fpga);
        check_trig(4'b0010);
        write_reg(REG_GRACTL, 8'h00);
        @(posedge clk_27mhz_fpga);
        check_trig(4'h0);
    endtask

    initial begin
        reset        = 1'b1;
        addr         = '0;
        wr_en        = 1'b0;
        wr_data      = '0;
        key_down     = 1'b0;
        key_code     = '0;
        trig_l       = 4'hf;
        pot_delay[0] = POT_HELD;
        pot_delay[1] = POT_HELD;
        errors       = 0;
        checks       = 0;
        repeat (10) @(posedge clk_27mhz_fpga);
        reset <= 1'b0;

        check_reset_state();
        run_keyboard_test();
        run_keyboard_disabled_test();
        run_pot_test();
        run_trigger_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/pokey_input_assertions.sv */
`default_nettype none

module pokey_input_assertions
    import pokey_pkg::*;
    import ctrl_pkg::*;
(
    input logic        clk_27mhz_fpga,
    input logic        reset,
    input logic        o2_tick,
    input logic        potgo,
    input ctrl_regs_t  regs,
    input ctrl_drive_t drive,
    input logic        irq
);

    // irq drops one cycle after IRQEN bit 6 clears
    a_irq_needs_irqen: assert property (@(posedge clk_27mhz_fpga) disable iff (reset)
        !regs.irqen[IRQ_KEY_BIT] |=> !irq)
        else $error("irq high while IRQEN keyboard bit is clear");

    // caps dumped right after POTGO
    a_potgo_dumps: assert property (@(posedge clk_27mhz_fpga) disable iff (reset)
        potgo |=> (drive.pot_rel == 2'b00))
        else $error("pot_rel not low after potgo");

    // scan position moves only on a phase-2 tick
    a_key_scan_steady: assert property (@(posedge clk_27mhz_fpga) disable iff (reset)
        !o2_tick |=> $stable(drive.key_scan))
        else $error("key_scan changed between ticks");

endmodule

bind pokey_input_top pokey_input_assertions i_pokey_input_assertions (
    .clk_27mhz_fpga (clk_27mhz_fpga),
    .reset          (reset),
    .o2_tick        (o2_tick),
    .potgo          (potgo),
    .regs           (regs),
    .drive          (drive),
    .irq            (irq)
);

`default_nettype wire

/* verilog/pokey_input_top.sv */
`default_nettype none

module pokey_input_top
    import pokey_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk_27mhz_fpga,
    input  logic        reset,
    input  logic [3:0]  addr,
    input  logic        wr_en,
    input  logic [7:0]  wr_data,
    input  ctrl_pads_t  pads,
    output logic [7:0]  rd_data,
    output ctrl_drive_t drive,
    output logic [3:0]  trig,
    output logic        irq
);

    logic       o2_tick;
    ctrl_regs_t regs;
    logic       potgo;
    logic [7:0] kbcode;
    logic       key_depr;
    logic       key_event;
    logic [7:0] pot0;
    logic [7:0] pot1;
    logic [1:0] allpot;

    // phase-2 enable shared by keypad and pot scans
    pokey_timing i_pokey_timing (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .o2_tick        (o2_tick)
    );

    pokey_reg_decode i_pokey_reg_decode (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .addr           (addr),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .regs           (regs),
        .potgo          (potgo)
    );

    pokey_keyscan i_pokey_keyscan (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .o2_tick        (o2_tick),
        .regs           (regs),
        .kr1_l          (pads.kr1_l),
        .key_scan       (drive.key_scan),
        .kbcode         (kbcode),
        .key_depr       (key_depr),
        .key_event      (key_event)
    );

    pokey_potscan i_pokey_potscan (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .o2_tick        (o2_tick),
        .potgo          (potgo),
        .pot_in         (pads.pot_in),
        .pot_rel        (drive.pot_rel),
        .pot0           (pot0),
        .pot1           (pot1),
        .allpot         (allpot)
    );

    pokey_trig i_pokey_trig (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .trig_l         (pads.trig_l),
        .regs           (regs),
        .trig           (trig)
    );

    pokey_read_mux i_pokey_read_mux (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .reset          (reset),
        .addr           (addr),
        .regs           (regs),
        .key_event      (key_event),
        .kbcode         (kbcode),
        .key_depr       (key_depr),
        .pot0           (pot0),
        .pot1           (pot1),
        .allpot         (allpot),
        .rd_data        (rd_data),
        .irq            (irq)
    );

endmodule

`default_nettype wire

/* verilog/pokey_read_mux.sv */
`default_nettype none

module pokey_read_mux
    import pokey_pkg::*;
(
    input  logic       clk_27mhz_fpga,
    input  logic       reset,
    input  logic [3:0] addr,
    input  ctrl_regs_t regs,
    input  logic       key_event,
    input  logic [7:0] kbcode,
    input  logic       key_depr,
    input  logic [7:0] pot0,
    input  logic [7:0] pot1,
    input  logic [1:0] allpot,
    output logic [7:0] rd_data,
    output logic       irq
);

    logic       irq_key;
    logic [7:0] irqst;
    logic [7:0] skstat;

    // keyboard interrupt pending
    // IRQEN clear forces it off, as on the real part
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            irq_key <= 1'b0;
        end else if (!regs.irqen[IRQ_KEY_BIT]) begin
            irq_key <= 1'b0;
        end else if (key_event) begin
            irq_key <= 1'b1;
        end
    end

    assign irq = irq_key;

    always_comb begin
        // IRQST is active low, a pending irq reads 0
        irqst = '1;
        irqst[IRQ_KEY_BIT] = ~irq_key;
        // SKSTAT bit 2 is the key-down flag, also active low
        skstat = '1;
        skstat[2] = ~key_depr;
    end

    // read data straight from addr
    always_comb begin
        case (addr)
            REG_POT0:   rd_data = pot0;
            REG_POT1:   rd_data = pot1;
            REG_ALLPOT: rd_data = {6'd0, allpot};
            REG_KBCODE: rd_data = kbcode;
            REG_IRQ:    rd_data = irqst;
            REG_SKCTL:  rd_data = skstat;
            default:    rd_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pokey_trig.sv */
`default_nettype none

module pokey_trig
    import pokey_pkg::*;
(
    input  logic       clk_27mhz_fpga,
    input  logic       reset,
    input  logic [3:0] trig_l,
    input  ctrl_regs_t regs,
    output logic [3:0] trig
);

    logic [3:0] trig_meta;
    logic [3:0] trig_sync;
    logic [3:0] trig_hold;
    logic       latch_mode;

    assign latch_mode = regs.gractl[GRACTL_LATCH_BIT];

    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            // buttons idle high
            trig_meta <= '1;
            trig_sync <= '1;
            trig_hold <= '0;
        end else begin
            trig_meta <= trig_l;
            trig_sync <= trig_meta;
            // sticky press while latching, dropped when latching turns off
            if (latch_mode) begin
                trig_hold <= trig_hold | ~trig_sync;
            end else begin
                trig_hold <= '0;
            end
        end
    end

    // live press also shows in latch mode, no extra cycle
    assign trig = latch_mode ? (trig_hold | ~trig_sync) : ~trig_sync;

endmodule

`default_nettype wire

/* pots/pokey_potscan.sv */
`default_nettype none

module pokey_potscan
    import pokey_pkg::*;
(
    input  logic       clk_27mhz_fpga,
    input  logic       reset,
    input  logic       o2_tick,
    input  logic       potgo,
    input  logic [1:0] pot_in,
    output logic [1:0] pot_rel,
    output logic [7:0] pot0,
    output logic [7:0] pot1,
    output logic [1:0] allpot
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DUMP,
        ST_COUNT
    } pot_state_t;

    // dump counter sized for POT_DUMP_TICKS
    localparam int DUMP_W = $clog2(POT_DUMP_TICKS + 1);
    localparam logic [DUMP_W-1:0] DUMP_LAST = DUMP_W'(POT_DUMP_TICKS - 1);

    pot_state_t        state;
    logic [DUMP_W-1:0] dump_cnt;
    logic [7:0]        count;
    logic [1:0]        pot_meta;
    logic [1:0]        pot_sync;
    logic              scan_done;

    // final step, any pot still open takes POT_MAX
    assign scan_done = (count == POT_MAX);

    // caps released only while counting
    assign pot_rel = {2{state == ST_COUNT}};

    // comparator line synchronizer
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            pot_meta <= '0;
            pot_sync <= '0;
        end else begin
            pot_meta <= pot_in;
            pot_sync <= pot_meta;
        end
    end

    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            state    <= ST_IDLE;
            dump_cnt <= '0;
            count    <= '0;
            allpot   <= '0;
            pot0     <= '0;
            pot1     <= '0;
        end else if (potgo) begin
            // start or restart a scan from any state
            state    <= ST_DUMP;
            dump_cnt <= '0;
            count    <= '0;
            allpot   <= 2'b11;
        end else if (o2_tick) begin
            case (state)
                ST_DUMP: begin
                    if (dump_cnt == DUMP_LAST) begin
                        state <= ST_COUNT;
                    end else begin
                        dump_cnt <= dump_cnt + 1'b1;
                    end
                end
                ST_COUNT: begin
                    // first tick a line is seen high latches the count
                    if (allpot[0] && (pot_sync[0] || scan_done)) begin
                        pot0      <= count;
                        allpot[0] <= 1'b0;
                    end
                    if (allpot[1] && (pot_sync[1] || scan_done)) begin
                        pot1      <= count;
                        allpot[1] <= 1'b0;
                    end
                    if (scan_done) begin
                        state <= ST_IDLE;
                    end else begin
                        count <= count + 8'd1;
                    end
                end
                default: begin
                    // idle until the next POTGO
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* keyboard/pokey_keyscan.sv */
`default_nettype none

module pokey_keyscan
    import pokey_pkg::*;
(
    input  logic       clk_27mhz_fpga,
    input  logic       reset,
    input  logic       o2_tick,
    input  ctrl_regs_t regs,
    input  logic       kr1_l,
    output logic [3:0] key_scan,
    output logic [7:0] kbcode,
    output logic       key_depr,
    output logic       key_event
);

    logic       kr1_meta;
    logic       kr1_sync;
    logic       scan_en;
    logic       hit;
    logic       scan_end;
    logic       found;
    logic [3:0] first_pos;
    logic       cur_found;
    logic [3:0] cur_pos;
    logic       last_valid;
    logic [3:0] last_pos;
    logic       repeat_key;
    logic       accept;

    assign scan_en  = regs.skctl[SKCTL_KEYSCAN_BIT];
    assign hit      = ~kr1_sync;
    // last step of a 16-step scan
    assign scan_end = (key_scan == 4'hf);

    // result of the scan that ends on this tick
    assign cur_found = found | hit;
    assign cur_pos   = found ? first_pos : key_scan;

    // same key still held, no new event
    assign repeat_key = key_depr && (kbcode[4:1] == cur_pos);
    // two scans in a row agree on the first key down
    assign accept = scan_end && cur_found && last_valid && (last_pos == cur_pos)
                    && !repeat_key;

    // return line synchronizer
    // settles well inside one scan step
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            kr1_meta <= 1'b1;
            kr1_sync <= 1'b1;
        end else begin
            kr1_meta <= kr1_l;
            kr1_sync <= kr1_meta;
        end
    end

    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            key_scan   <= '0;
            found      <= 1'b0;
            last_valid <= 1'b0;
            key_depr   <= 1'b0;
            key_event  <= 1'b0;
            kbcode     <= '0;
        end else begin
            key_event <= 1'b0;
            if (!scan_en) begin
                // scan off, counter holds and debounce starts over
                found      <= 1'b0;
                last_valid <= 1'b0;
                key_depr   <= 1'b0;
            end else if (o2_tick) begin
                // kr1 reflects the position held since the last tick
                key_scan <= key_scan + 4'd1;
                if (scan_end) begin
                    found      <= 1'b0;
                    last_valid <= cur_found;
                    if (!cur_found) begin
                        // a whole scan with nothing down
                        key_depr <= 1'b0;
                    end
                    if (accept) begin
                        // scan code times two, top bits clear
                        kbcode    <= {3'b000, cur_pos, 1'b0};
                        key_depr  <= 1'b1;
                        key_event <= 1'b1;
                    end
                end else if (hit && !found) begin
                    found <= 1'b1;
                end
            end
        end
    end

    // scan positions, only meaningful alongside found and last_valid
    always_ff @(posedge clk_27mhz_fpga) begin
        if (scan_en && o2_tick) begin
            if (scan_end) begin
                last_pos <= cur_pos;
            end else if (hit && !found) begin
                first_pos <= key_scan;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pokey_reg_decode.sv */
`default_nettype none

module pokey_reg_decode
    import pokey_pkg::*;
(
    input  logic       clk_27mhz_fpga,
    input  logic       reset,
    input  logic [3:0] addr,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    output ctrl_regs_t regs,
    output logic       potgo
);

    logic potgo_hit;

    // POTGO is a strobe only, the data byte does not matter
    assign potgo_hit = wr_en && (addr == REG_POTGO);

    // pulse for one cycle after the write edge
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            potgo <= 1'b0;
        end else begin
            potgo <= potgo_hit;
        end
    end

    // control registers
    // all clear after reset so scan and irq start off
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            regs <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_SKCTL: begin
                    regs.skctl <= wr_data;
                end
                // write side of address 14
                REG_IRQ: begin
                    regs.irqen <= wr_data;
                end
                REG_GRACTL: begin
                    regs.gractl <= wr_data;
                end
                default: begin
                    // read-only or unused address, nothing to load
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/pokey_timing.sv */
`default_nettype none

module pokey_timing
    import pokey_pkg::*;
(
    input  logic clk_27mhz_fpga,
    input  logic reset,
    output logic o2_tick
);

    // counter wide enough for O2_DIV states, at least one bit
    localparam int CNT_W = (O2_DIV > 1) ? $clog2(O2_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(O2_DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    // one-clock enable per wrap instead of a divided clock
    always_ff @(posedge clk_27mhz_fpga) begin
        if (reset) begin
            div_cnt <= '0;
            o2_tick <= 1'b0;
        end else begin
            o2_tick <= (div_cnt == CNT_LAST);
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // controller pad inputs
    typedef struct packed {
        // keypad return line, low when the scanned key is down
        logic       kr1_l;
        // pot comparator lines, high once the cap has charged
        logic [1:0] pot_in;
        // trigger buttons, low when pressed
        logic [3:0] trig_l;
    } ctrl_pads_t;

    // controller pad outputs
    typedef struct packed {
        // keypad scan position
        logic [3:0] key_scan;
        // pot release, low dumps the caps
        logic [1:0] pot_rel;
    } ctrl_drive_t;

endpackage

`default_nettype wire

/* common/pokey_pkg.sv */
`default_nettype none

package pokey_pkg;

    // register map, 4-bit addresses
    // reads and writes share some addresses, as on the real part
    localparam logic [3:0] REG_POT0   = 4'd0;
    localparam logic [3:0] REG_POT1   = 4'd1;
    localparam logic [3:0] REG_ALLPOT = 4'd8;
    localparam logic [3:0] REG_KBCODE = 4'd9;
    // write only, data is ignored
    localparam logic [3:0] REG_POTGO  = 4'd11;
    // GRACTL borrowed from GTIA, free write slot in POKEY space
    localparam logic [3:0] REG_GRACTL = 4'd13;
    // read IRQST, write IRQEN
    localparam logic [3:0] REG_IRQ    = 4'd14;
    // read SKSTAT, write SKCTL
    localparam logic [3:0] REG_SKCTL  = 4'd15;

    // keyboard interrupt bit in IRQEN and IRQST
    localparam int IRQ_KEY_BIT = 6;
    // SKCTL bit that enables the keypad scan
    localparam int SKCTL_KEYSCAN_BIT = 1;
    // GRACTL bit that turns on trigger latching
    localparam int GRACTL_LATCH_BIT = 2;

    // clocks per phase-2 tick
    // short for simulation, 1800 on the board
    localparam int O2_DIV = 4;

    // ticks the pot capacitors stay dumped after POTGO
    localparam int POT_DUMP_TICKS = 2;

    // last pot count, an open pot line reads this
    localparam logic [7:0] POT_MAX = 8'd228;

    // control registers written through the register port
    typedef struct packed {
        logic [7:0] skctl;
        logic [7:0] irqen;
        logic [7:0] gractl;
    } ctrl_regs_t;

endpackage

`default_nettype wire
